// File: source/sdCardPkg.sv
package sdCardPkg;

    // ==================================================
    // Field widths
    // ==================================================
    typedef logic [5:0]  cmdIndexT;
    typedef logic [31:0] cmdArgT;
    typedef logic [15:0] rcaT;
    typedef logic [6:0]  crc7T;
    typedef logic [15:0] crc16T;
    typedef logic [3:0]  datT;

    // ==================================================
    // Command indices
    // ==================================================
    localparam cmdIndexT cmdGoIdle    = 6'd0;
    localparam cmdIndexT cmdSendRca   = 6'd3;
    localparam cmdIndexT cmdSelect    = 6'd7;
    localparam cmdIndexT cmdIfCond    = 6'd8;
    localparam cmdIndexT cmdStop      = 6'd12;
    localparam cmdIndexT cmdReadMulti = 6'd18;
    localparam cmdIndexT cmdAppCmd    = 6'd55;
    localparam cmdIndexT acmdOpCond   = 6'd41;

    // Command and response frames on CMD
    localparam int frameBits = 48;

    // Response payloads
    localparam logic [15:0] statusRca = 16'h0520;
    localparam cmdArgT      statusR1  = 32'h0000_0900;
    // Busy bit set, card powered up and ready
    localparam cmdArgT      ocrReady  = 32'hC1FF_8080;
    localparam cmdIndexT    r3Index   = 6'h3F;

    typedef struct packed {
        cmdIndexT index;
        cmdArgT   arg;
    } cmdFrameT;

    typedef struct packed {
        cmdIndexT index;
        cmdArgT   arg;
        logic     crcOnes;
    } respFrameT;

endpackage

// File: source/sdCrc7.sv
`timescale 1ns/10ps

module sdCrc7 (
    input  logic             clk,
    input  logic             rst_,
    input  logic             clear,
    input  logic             enable,
    input  logic             din,
    output sdCardPkg::crc7T  crc
);
    sdCardPkg::crc7T base;
    sdCardPkg::crc7T crcNext;
    logic fb;

    // Clear together with enable starts a fresh CRC with din
    assign base = clear ? '0 : crc;
    assign fb = din ^ base[6];
    // x^7 + x^3 + 1
    assign crcNext = {base[5:3], base[2] ^ fb, base[1:0], fb};

    always_ff @(posedge clk) begin
        if (!rst_) begin
            crc <= '0;
        end else if (enable) begin
            crc <= crcNext;
        end else if (clear) begin
            crc <= '0;
        end
    end

endmodule

// File: source/sdCrc16.sv
`timescale 1ns/10ps

module sdCrc16 (
    input  logic              clk,
    input  logic              rst_,
    input  logic              clear,
    input  logic              enable,
    input  logic              din,
    output sdCardPkg::crc16T  crc
);
    sdCardPkg::crc16T base;
    sdCardPkg::crc16T crcNext;
    logic fb;

    assign base = clear ? '0 : crc;
    assign fb = din ^ base[15];
    // x^16 + x^12 + x^5 + 1
    assign crcNext = {base[14:12], base[11] ^ fb, base[10:5], base[4] ^ fb, base[3:0], fb};

    always_ff @(posedge clk) begin
        if (!rst_) begin
            crc <= '0;
        end else if (enable) begin
            crc <= crcNext;
        end else if (clear) begin
            crc <= '0;
        end
    end

endmodule

// File: source/sdCmdReceiver.sv
`timescale 1ns/10ps

module sdCmdReceiver (
    input  logic                 clk,
    input  logic                 rst_,
    input  logic                 cmdIn,
    output logic                 cmdValid,
    output sdCardPkg::cmdFrameT  cmdFrame
);
    localparam int crcBits = sdCardPkg::frameBits - 8;

    typedef enum logic {stIdle, stReceive} stateT;

    stateT state;
    logic [5:0] bitCnt;
    logic [sdCardPkg::frameBits-2:0] shiftReg;
    logic [sdCardPkg::frameBits-1:0] frame;
    logic lastBit;
    logic frameOk;
    logic crcEnable;
    sdCardPkg::crc7T crc;

    // Whole frame as seen in the cycle of the end bit
    assign frame = {shiftReg, cmdIn};
    assign lastBit = (state == stReceive) && (bitCnt == 6'(sdCardPkg::frameBits - 1));

    // Transmission bit, CRC7 and end bit
    assign frameOk = frame[sdCardPkg::frameBits-2] && (frame[7:1] == crc) && frame[0];

    // Start bit plus the next 39 bits feed the CRC
    assign crcEnable = ((state == stIdle) && !cmdIn) ||
                       ((state == stReceive) && (bitCnt < 6'(crcBits)));

    sdCrc7 crcInst (
        .clk    (clk),
        .rst_   (rst_),
        .clear  (state == stIdle),
        .enable (crcEnable),
        .din    (cmdIn),
        .crc    (crc)
    );

    always_ff @(posedge clk) begin
        shiftReg <= frame[sdCardPkg::frameBits-2:0];
        if (lastBit) begin
            cmdFrame.index <= frame[45:40];
            cmdFrame.arg   <= frame[39:8];
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_) begin
            state    <= stIdle;
            bitCnt   <= '0;
            cmdValid <= 1'b0;
        end else begin
            cmdValid <= lastBit && frameOk;
            case (state)
                stIdle: begin
                    if (!cmdIn) begin
                        state  <= stReceive;
                        bitCnt <= 6'd1;
                    end
                end
                stReceive: begin
                    bitCnt <= bitCnt + 6'd1;
                    if (lastBit) begin
                        state <= stIdle;
                    end
                end
                default: state <= stIdle;
            endcase
        end
    end

endmodule

// File: source/sdCmdHandler.sv
`timescale 1ns/10ps

module sdCmdHandler #(
    parameter sdCardPkg::rcaT cardRca = 16'hAAAA
) (
    input  logic                  clk,
    input  logic                  rst_,
    input  logic                  cmdValid,
    input  sdCardPkg::cmdFrameT   cmdFrame,
    input  logic                  respDone,
    output logic                  respValid,
    output sdCardPkg::respFrameT  respFrame,
    output logic                  readActive
);
    sdCardPkg::rcaT rca;
    logic appCmd;
    logic respHit;
    logic pendStart;
    logic pendStop;
    sdCardPkg::respFrameT respNext;

    // ==================================================
    // Response decode
    // ==================================================
    always_comb begin
        respHit = 1'b0;
        respNext.index = cmdFrame.index;
        respNext.arg = sdCardPkg::statusR1;
        respNext.crcOnes = 1'b0;
        if (appCmd && (cmdFrame.index == sdCardPkg::acmdOpCond)) begin
            // R3 carries no real index or CRC
            respHit = 1'b1;
            respNext.index = sdCardPkg::r3Index;
            respNext.arg = sdCardPkg::ocrReady;
            respNext.crcOnes = 1'b1;
        end else begin
            case (cmdFrame.index)
                sdCardPkg::cmdSendRca: begin
                    respHit = 1'b1;
                    respNext.arg = {cardRca, sdCardPkg::statusRca};
                end
                sdCardPkg::cmdSelect: respHit = (cmdFrame.arg[31:16] == rca);
                sdCardPkg::cmdIfCond: begin
                    respHit = 1'b1;
                    respNext.arg = {20'd0, cmdFrame.arg[11:0]};
                end
                sdCardPkg::cmdStop, sdCardPkg::cmdReadMulti, sdCardPkg::cmdAppCmd: begin
                    respHit = 1'b1;
                end
                default: respHit = 1'b0;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (cmdValid) begin
            respFrame <= respNext;
        end
    end

    // ==================================================
    // Card state and read control
    // ==================================================
    always_ff @(posedge clk) begin
        if (!rst_) begin
            rca        <= '0;
            appCmd     <= 1'b0;
            respValid  <= 1'b0;
            pendStart  <= 1'b0;
            pendStop   <= 1'b0;
            readActive <= 1'b0;
        end else begin
            respValid <= cmdValid && respHit;
            // Read starts or stops once its response is on the wire
            if (respDone) begin
                if (pendStart) begin
                    readActive <= 1'b1;
                end
                if (pendStop) begin
                    readActive <= 1'b0;
                end
                pendStart <= 1'b0;
                pendStop  <= 1'b0;
            end
            if (cmdValid) begin
                // Flag lives for one command only
                appCmd <= (cmdFrame.index == sdCardPkg::cmdAppCmd);
                if (cmdFrame.index == sdCardPkg::cmdGoIdle) begin
                    rca <= '0;
                end
                if (cmdFrame.index == sdCardPkg::cmdSendRca) begin
                    rca <= cardRca;
                end
                if (respHit) begin
                    pendStart <= !appCmd && (cmdFrame.index == sdCardPkg::cmdReadMulti);
                    pendStop  <= !appCmd && (cmdFrame.index == sdCardPkg::cmdStop);
                end
            end
        end
    end

endmodule

// File: source/sdRespSender.sv
`timescale 1ns/10ps

module sdRespSender #(
    parameter int respDelay = 2
) (
    input  logic                  clk,
    input  logic                  rst_,
    input  logic                  respValid,
    input  sdCardPkg::respFrameT  respFrame,
    output logic                  cmdOut,
    output logic                  cmdOe,
    output logic                  respDone
);
    localparam int dlyW = $clog2(respDelay + 2);
    // Start, transmission, index and argument
    localparam int bodyBits = sdCardPkg::frameBits - 8;

    typedef enum logic [1:0] {stIdle, stDelay, stShift} stateT;

    stateT state;
    logic [dlyW-1:0] dlyCnt;
    logic [5:0] bitCnt;
    logic [5:0] nextIdx;
    logic drive;
    logic [bodyBits-1:0] txSr;
    logic crcOnes;
    sdCardPkg::crc7T crc;

    // drive marks an edge that puts bit nextIdx on CMD
    always_comb begin
        drive = 1'b0;
        nextIdx = '0;
        case (state)
            // At least one idle cycle, even for a zero delay
            stDelay: drive = (dlyCnt <= dlyW'(1));
            stShift: begin
                drive = (bitCnt != 6'(sdCardPkg::frameBits - 1));
                nextIdx = bitCnt + 6'd1;
            end
            default: drive = 1'b0;
        endcase
    end

    sdCrc7 crcInst (
        .clk    (clk),
        .rst_   (rst_),
        .clear  (state != stShift),
        .enable (drive && (nextIdx < 6'(bodyBits))),
        .din    (txSr[bodyBits-1]),
        .crc    (crc)
    );

    always_ff @(posedge clk) begin
        if ((state == stIdle) && respValid) begin
            txSr    <= {2'b00, respFrame.index, respFrame.arg};
            crcOnes <= respFrame.crcOnes;
        end else if (drive && (nextIdx < 6'(bodyBits))) begin
            txSr <= txSr << 1;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_) begin
            state    <= stIdle;
            dlyCnt   <= '0;
            bitCnt   <= '0;
            cmdOut   <= 1'b1;
            cmdOe    <= 1'b0;
            respDone <= 1'b0;
        end else begin
            respDone <= 1'b0;
            case (state)
                stIdle: begin
                    if (respValid) begin
                        state  <= stDelay;
                        dlyCnt <= dlyW'(respDelay);
                    end
                end
                stDelay: begin
                    if (drive) begin
                        state <= stShift;
                    end else begin
                        dlyCnt <= dlyCnt - dlyW'(1);
                    end
                end
                stShift: begin
                    // End bit was on the line, release CMD
                    if (!drive) begin
                        state    <= stIdle;
                        cmdOe    <= 1'b0;
                        cmdOut   <= 1'b1;
                        respDone <= 1'b1;
                    end
                end
                default: state <= stIdle;
            endcase
            if (drive) begin
                cmdOe  <= 1'b1;
                bitCnt <= nextIdx;
                if (nextIdx < 6'(bodyBits)) begin
                    cmdOut <= txSr[bodyBits-1];
                end else if (nextIdx < 6'(sdCardPkg::frameBits - 1)) begin
                    cmdOut <= crcOnes | crc[sdCardPkg::frameBits - 2 - nextIdx];
                end else begin
                    cmdOut <= 1'b1;
                end
            end
        end
    end

endmodule

// File: source/sdReadSender.sv
`timescale 1ns/10ps

module sdReadSender #(
    parameter int blockBytes = 8
) (
    input  logic            clk,
    input  logic            rst_,
    input  logic            readActive,
    output sdCardPkg::datT  datOut,
    output logic            datOe
);
    localparam int dataBits = blockBytes * 8;
    localparam int cntW = $clog2(dataBits > 16 ? dataBits : 16);

    typedef enum logic [2:0] {stIdle, stStart, stData, stCrc, stEnd, stGap} stateT;

    stateT state;
    stateT stateNext;
    logic [cntW-1:0] cnt;
    logic [cntW-1:0] cntNext;
    logic [7:0] byteVal;
    logic dataBit;
    sdCardPkg::datT crcBits;

    // state and cnt describe what is on DAT in the current cycle
    always_comb begin
        stateNext = state;
        cntNext = cnt + cntW'(1);
        case (state)
            stIdle: begin
                cntNext = '0;
                if (readActive) begin
                    stateNext = stStart;
                end
            end
            stStart: begin
                stateNext = stData;
                cntNext = '0;
            end
            stData: begin
                if (cnt == cntW'(dataBits - 1)) begin
                    stateNext = stCrc;
                    cntNext = '0;
                end
            end
            stCrc: begin
                if (cnt == cntW'(15)) begin
                    stateNext = stEnd;
                    cntNext = '0;
                end
            end
            stEnd: begin
                stateNext = stGap;
                cntNext = '0;
            end
            stGap: begin
                if (cnt == cntW'(1)) begin
                    stateNext = readActive ? stStart : stIdle;
                    cntNext = '0;
                end
            end
            default: stateNext = stIdle;
        endcase
    end

    // Counting bytes, MSB first
    assign byteVal = 8'(cntNext >> 3);
    assign dataBit = byteVal[~cntNext[2:0]];

    for (genvar lane = 0; lane < 4; lane++) begin : genLane
        sdCardPkg::crc16T laneCrc;

        sdCrc16 crcInst (
            .clk    (clk),
            .rst_   (rst_),
            .clear  (state == stStart),
            .enable (stateNext == stData),
            .din    (dataBit),
            .crc    (laneCrc)
        );

        assign crcBits[lane] = laneCrc[4'hF - cntNext[3:0]];
    end

    always_ff @(posedge clk) begin
        if (!rst_) begin
            state  <= stIdle;
            cnt    <= '0;
            datOe  <= 1'b0;
            datOut <= 4'hF;
        end else begin
            state <= stateNext;
            cnt   <= cntNext;
            datOe <= (stateNext inside {stStart, stData, stCrc, stEnd});
            case (stateNext)
                stStart: datOut <= 4'h0;
                stData:  datOut <= {4{dataBit}};
                stCrc:   datOut <= crcBits;
                default: datOut <= 4'hF;
            endcase
        end
    end

endmodule

// File: source/sdCardEmu.sv
`timescale 1ns/10ps

module sdCardEmu #(
    parameter sdCardPkg::rcaT cardRca = 16'hAAAA,
    parameter int respDelay = 2,
    parameter int blockBytes = 8
) (
    input  logic            clk,
    input  logic            rst_,
    input  logic            cmdIn,
    // DAT pin input, kept for pin compatibility only
    input  sdCardPkg::datT  datIn,
    output logic            cmdOut,
    output logic            cmdOe,
    output sdCardPkg::datT  datOut,
    output logic            datOe
);
    logic cmdValid;
    sdCardPkg::cmdFrameT cmdFrame;
    logic respValid;
    sdCardPkg::respFrameT respFrame;
    logic respDone;
    logic readActive;

    // ==================================================
    // CMD line
    // ==================================================
    sdCmdReceiver cmdReceiverInst (
        .clk      (clk),
        .rst_     (rst_),
        .cmdIn    (cmdIn),
        .cmdValid (cmdValid),
        .cmdFrame (cmdFrame)
    );

    sdCmdHandler #(.cardRca(cardRca)) cmdHandlerInst (
        .clk        (clk),
        .rst_       (rst_),
        .cmdValid   (cmdValid),
        .cmdFrame   (cmdFrame),
        .respDone   (respDone),
        .respValid  (respValid),
        .respFrame  (respFrame),
        .readActive (readActive)
    );

    sdRespSender #(.respDelay(respDelay)) respSenderInst (
        .clk       (clk),
        .rst_      (rst_),
        .respValid (respValid),
        .respFrame (respFrame),
        .cmdOut    (cmdOut),
        .cmdOe     (cmdOe),
        .respDone  (respDone)
    );

    // ==================================================
    // DAT lines
    // ==================================================
    sdReadSender #(.blockBytes(blockBytes)) readSenderInst (
        .clk        (clk),
        .rst_       (rst_),
        .readActive (readActive),
        .datOut     (datOut),
        .datOe      (datOe)
    );

endmodule

// File: tests/sdCardChecker.sv
`timescale 1ns/10ps

module sdCardChecker #(
    parameter int respDelay = 2,
    parameter int blockBytes = 8
) (
    input  logic                 clk,
    input  logic                 rst_,
    input  logic                 cmdOut,
    input  logic                 cmdOe,
    input  sdCardPkg::datT       datOut,
    input  logic                 datOe,
    input  logic                 cmdEnd,
    input  logic                 rowDone,
    input  logic                 expResp,
    input  sdCardPkg::cmdIndexT  expIndex,
    input  sdCardPkg::cmdArgT    expArg,
    input  logic [3:0]           expBlocks,
    output int                   mismatchCount,
    output int                   frameCount
);
    localparam int dataBits = blockBytes * 8;
    // Start, data, CRC16 and end cycles
    localparam int blockLen = dataBits + 18;

    logic [47:0] respBits;
    int respCnt;
    int sinceEnd;
    int respSeen;
    int blockSeen;
    int blkCnt;
    int rowNum;
    sdCardPkg::crc16T calcCrc [4];
    sdCardPkg::crc16T rxCrc [4];
    logic [7:0] byteVal;
    sdCardPkg::datT expDat;

    function automatic sdCardPkg::crc7T crc7Over40(input logic [39:0] bits);
        sdCardPkg::crc7T c;
        c = '0;
        for (int i = 39; i >= 0; i--) begin
            if (bits[i] ^ c[6]) begin
                c = {c[5:0], 1'b0} ^ 7'h09;
            end else begin
                c = {c[5:0], 1'b0};
            end
        end
        return c;
    endfunction

    function automatic sdCardPkg::crc16T crc16Step(input sdCardPkg::crc16T c, input logic d);
        sdCardPkg::crc16T n;
        n = {c[14:0], 1'b0};
        if (d ^ c[15]) begin
            n = n ^ 16'h1021;
        end
        return n;
    endfunction

    task reportMismatch(input string name, input logic [31:0] got, input logic [31:0] want);
        $display("mismatch %s: got %0h expected %0h", name, got, want);
        mismatchCount++;
    endtask

    task checkResp();
        sdCardPkg::crc7T wantCrc;
        // R3 has all ones in place of the CRC
        if (expResp && (expIndex == sdCardPkg::r3Index)) begin
            wantCrc = 7'h7F;
        end else begin
            wantCrc = crc7Over40(respBits[47:8]);
        end
        if (respBits[47:46] !== 2'b00) begin
            reportMismatch("cmdOut start and transmission bits", respBits[47:46], 0);
        end
        if (expResp && (respBits[45:40] !== expIndex)) begin
            reportMismatch("cmdOut index", respBits[45:40], expIndex);
        end
        if (expResp && (respBits[39:8] !== expArg)) begin
            reportMismatch("cmdOut argument", respBits[39:8], expArg);
        end
        if (respBits[7:1] !== wantCrc) begin
            reportMismatch("cmdOut CRC7", respBits[7:1], wantCrc);
        end
        if (respBits[0] !== 1'b1) begin
            reportMismatch("cmdOut end bit", respBits[0], 1);
        end
    endtask

    task checkRow();
        if (respSeen < int'(expResp)) begin
            $display("Row %0d: response frame missing", rowNum);
            frameCount++;
        end else if (respSeen > int'(expResp)) begin
            $display("Row %0d: %0d response frames where %0d expected", rowNum, respSeen,
                     int'(expResp));
            frameCount++;
        end
        if (blockSeen != int'(expBlocks)) begin
            $display("Row %0d: %0d data blocks started where %0d expected", rowNum, blockSeen,
                     int'(expBlocks));
            frameCount++;
        end
        respSeen = 0;
        blockSeen = 0;
        rowNum++;
    endtask

    always @(posedge clk) begin
        if (!rst_) begin
            respCnt = 0;
            sinceEnd = 0;
            respSeen = 0;
            blockSeen = 0;
            blkCnt = 0;
            rowNum = 0;
            mismatchCount = 0;
            frameCount = 0;
        end else begin
            if (rowDone) begin
                checkRow();
            end
            sinceEnd = cmdEnd ? 0 : sinceEnd + 1;

            // ==================================================
            // CMD responses
            // ==================================================
            if (cmdOe) begin
                // Receiver 1, handler 1, then respDelay idle cycles
                if ((respCnt == 0) && (sinceEnd != respDelay + 3)) begin
                    reportMismatch("cmdOut start cycle", sinceEnd, respDelay + 3);
                end
                respBits = {respBits[46:0], cmdOut};
                respCnt++;
                if (respCnt == sdCardPkg::frameBits) begin
                    checkResp();
                    respSeen++;
                    respCnt = 0;
                end
            end else if (respCnt != 0) begin
                $display("Response frame broke off after %0d bits", respCnt);
                frameCount++;
                respCnt = 0;
            end

            // ==================================================
            // DAT blocks
            // ==================================================
            if (datOe) begin
                if (blkCnt == 0) begin
                    blockSeen++;
                    if (datOut !== 4'h0) begin
                        reportMismatch("datOut start bit", datOut, 0);
                    end
                    for (int l = 0; l < 4; l++) begin
                        calcCrc[l] = '0;
                        rxCrc[l] = '0;
                    end
                end else if (blkCnt <= dataBits) begin
                    // Byte k holds k, MSB first, same bit on every lane
                    byteVal = 8'((blkCnt - 1) / 8);
                    expDat = {4{byteVal[7 - ((blkCnt - 1) % 8)]}};
                    if (datOut !== expDat) begin
                        reportMismatch("datOut data", datOut, expDat);
                    end
                    for (int l = 0; l < 4; l++) begin
                        calcCrc[l] = crc16Step(calcCrc[l], datOut[l]);
                    end
                end else if (blkCnt <= dataBits + 16) begin
                    for (int l = 0; l < 4; l++) begin
                        rxCrc[l] = {rxCrc[l][14:0], datOut[l]};
                    end
                end else begin
                    for (int l = 0; l < 4; l++) begin
                        if (rxCrc[l] !== calcCrc[l]) begin
                            reportMismatch($sformatf("datOut[%0d] CRC16", l), rxCrc[l],
                                           calcCrc[l]);
                        end
                    end
                    if (datOut !== 4'hF) begin
                        reportMismatch("datOut end bit", datOut, 4'hF);
                    end
                end
                blkCnt = (blkCnt == blockLen - 1) ? 0 : blkCnt + 1;
            end else if (blkCnt != 0) begin
                $display("Data block broke off after %0d cycles", blkCnt);
                frameCount++;
                blkCnt = 0;
            end
        end
    end

endmodule

// File: tests/sdCardTb.sv
`timescale 1ns/10ps

module sdCardTb;
    localparam sdCardPkg::rcaT cardRca = 16'hAAAA;
    localparam int respDelay = 2;
    localparam int blockBytes = 8;
    // One block plus the two gap cycles
    localparam int blockCycles = blockBytes * 8 + 20;
    localparam int numRows = 13;

    typedef struct packed {
        sdCardPkg::cmdFrameT cmd;
        logic                badCrc;
        logic                expResp;
        sdCardPkg::cmdIndexT expIndex;
        sdCardPkg::cmdArgT   expArg;
        logic [3:0]          expBlocks;
    } rowT;

    logic clk;
    logic rst_;
    logic cmdIn;
    sdCardPkg::datT datIn;
    logic cmdOut;
    logic cmdOe;
    sdCardPkg::datT datOut;
    logic datOe;
    logic cmdEnd;
    logic rowDone;
    logic expResp;
    sdCardPkg::cmdIndexT expIndex;
    sdCardPkg::cmdArgT expArg;
    logic [3:0] expBlocks;
    int mismatchCount;
    int frameCount;
    int cycleCount;
    int cycleLimit;
    integer seed;
    rowT stimRows [numRows];
    sdCardPkg::cmdArgT ifArg [3];

    sdCardEmu #(
        .cardRca    (cardRca),
        .respDelay  (respDelay),
        .blockBytes (blockBytes)
    ) sdCardEmu_inst (
        .clk    (clk),
        .rst_   (rst_),
        .cmdIn  (cmdIn),
        .datIn  (datIn),
        .cmdOut (cmdOut),
        .cmdOe  (cmdOe),
        .datOut (datOut),
        .datOe  (datOe)
    );

    sdCardChecker #(
        .respDelay  (respDelay),
        .blockBytes (blockBytes)
    ) sdCardCheckerInst (
        .clk           (clk),
        .rst_          (rst_),
        .cmdOut        (cmdOut),
        .cmdOe         (cmdOe),
        .datOut        (datOut),
        .datOe         (datOe),
        .cmdEnd        (cmdEnd),
        .rowDone       (rowDone),
        .expResp       (expResp),
        .expIndex      (expIndex),
        .expArg        (expArg),
        .expBlocks     (expBlocks),
        .mismatchCount (mismatchCount),
        .frameCount    (frameCount)
    );

    function automatic sdCardPkg::crc7T calcCrc7(input logic [39:0] bits);
        sdCardPkg::crc7T c;
        c = '0;
        for (int i = 39; i >= 0; i--) begin
            if (bits[i] ^ c[6]) begin
                c = {c[5:0], 1'b0} ^ 7'h09;
            end else begin
                c = {c[5:0], 1'b0};
            end
        end
        return c;
    endfunction

    function automatic rowT makeRow(input sdCardPkg::cmdIndexT index,
                                    input sdCardPkg::cmdArgT arg, input logic corrupt,
                                    input logic respOn, input sdCardPkg::cmdIndexT respIndex,
                                    input sdCardPkg::cmdArgT respArg, input logic [3:0] blocks);
        rowT row;
        row.cmd.index = index;
        row.cmd.arg = arg;
        row.badCrc = corrupt;
        row.expResp = respOn;
        row.expIndex = respIndex;
        row.expArg = respArg;
        row.expBlocks = blocks;
        return row;
    endfunction

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= cycleLimit) begin
            $display("Timeout: run still going after %0d cycles", cycleCount);
            $display("Done: errors found");
            $finish;
        end
    end

    initial begin
        logic [47:0] frame;
        sdCardPkg::crc7T crc;
        int idle;
        rst_ = 1'b0;
        cmdIn = 1'b1;
        datIn = 4'hF;
        cmdEnd = 1'b0;
        rowDone = 1'b0;
        expResp = 1'b0;
        expIndex = '0;
        expArg = '0;
        expBlocks = '0;
        cycleCount = 0;
        seed = 32'h628a_aa46;
        for (int i = 0; i < 3; i++) begin
            ifArg[i] = $random(seed);
        end

        // ==================================================
        // Stimulus table
        // ==================================================
        stimRows[0] = makeRow(sdCardPkg::cmdGoIdle, '0, 0, 0, '0, '0, 0);
        stimRows[1] = makeRow(sdCardPkg::cmdIfCond, ifArg[0], 0, 1, sdCardPkg::cmdIfCond,
                              {20'd0, ifArg[0][11:0]}, 0);
        stimRows[2] = makeRow(sdCardPkg::cmdSendRca, '0, 0, 1, sdCardPkg::cmdSendRca,
                              {cardRca, sdCardPkg::statusRca}, 0);
        stimRows[3] = makeRow(sdCardPkg::cmdSelect, {cardRca, 16'h0000}, 0, 1,
                              sdCardPkg::cmdSelect, sdCardPkg::statusR1, 0);
        // Wrong RCA
        stimRows[4] = makeRow(sdCardPkg::cmdSelect, {16'h1234, 16'h0000}, 0, 0, '0, '0, 0);
        stimRows[5] = makeRow(sdCardPkg::cmdAppCmd, {cardRca, 16'h0000}, 0, 1,
                              sdCardPkg::cmdAppCmd, sdCardPkg::statusR1, 0);
        stimRows[6] = makeRow(sdCardPkg::acmdOpCond, 32'h40FF_8000, 0, 1, sdCardPkg::r3Index,
                              sdCardPkg::ocrReady, 0);
        // No CMD55 in front this time
        stimRows[7] = makeRow(sdCardPkg::acmdOpCond, 32'h40FF_8000, 0, 0, '0, '0, 0);
        stimRows[8] = makeRow(sdCardPkg::cmdIfCond, ifArg[1], 1, 0, '0, '0, 0);
        stimRows[9] = makeRow(sdCardPkg::cmdIfCond, ifArg[1], 0, 1, sdCardPkg::cmdIfCond,
                              {20'd0, ifArg[1][11:0]}, 0);
        stimRows[10] = makeRow(sdCardPkg::cmdReadMulti, '0, 0, 1, sdCardPkg::cmdReadMulti,
                               sdCardPkg::statusR1, 2);
        // The block under way when the CMD12 response ends is the last one
        stimRows[11] = makeRow(sdCardPkg::cmdStop, '0, 0, 1, sdCardPkg::cmdStop,
                               sdCardPkg::statusR1, 1);
        stimRows[12] = makeRow(sdCardPkg::cmdIfCond, ifArg[2], 0, 1, sdCardPkg::cmdIfCond,
                               {20'd0, ifArg[2][11:0]}, 0);

        cycleLimit = 0;
        for (int r = 0; r < numRows; r++) begin
            cycleLimit = cycleLimit + 2 * (sdCardPkg::frameBits + respDelay + 50 +
                         int'(stimRows[r].expBlocks) * blockCycles);
        end

        repeat (2) @(posedge clk);
        rst_ <= 1'b1;
        @(posedge clk);

        for (int r = 0; r < numRows; r++) begin
            crc = calcCrc7({2'b01, stimRows[r].cmd});
            if (stimRows[r].badCrc) begin
                crc = ~crc;
            end
            frame = {2'b01, stimRows[r].cmd, crc, 1'b1};
            // About 55 cycles for the response and one period per further block
            idle = respDelay + 60;
            if (stimRows[r].expBlocks != 0) begin
                idle = idle + (int'(stimRows[r].expBlocks) - 1) * blockCycles;
            end
            for (int b = sdCardPkg::frameBits - 1; b >= 0; b--) begin
                @(posedge clk);
                cmdIn     <= frame[b];
                cmdEnd    <= (b == 0);
                rowDone   <= 1'b0;
                expResp   <= stimRows[r].expResp;
                expIndex  <= stimRows[r].expIndex;
                expArg    <= stimRows[r].expArg;
                expBlocks <= stimRows[r].expBlocks;
            end
            @(posedge clk);
            cmdIn  <= 1'b1;
            cmdEnd <= 1'b0;
            repeat (idle) @(posedge clk);
            rowDone <= 1'b1;
        end
        @(posedge clk);
        rowDone <= 1'b0;
        repeat (2) @(posedge clk);

        $display("Errors: %0d mismatch, %0d framing", mismatchCount, frameCount);
        if (mismatchCount + frameCount == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

// File: sim.f
source/sdCardPkg.sv
source/sdCrc7.sv
source/sdCrc16.sv
source/sdCmdReceiver.sv
source/sdCmdHandler.sv
source/sdRespSender.sv
source/sdReadSender.sv
source/sdCardEmu.sv
tests/sdCardChecker.sv
tests/sdCardTb.sv
